/* Makefile */
TOP = tb_udp_loopback

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sim.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sim.f

clean:
	rm -rf obj_dir

/* sim.f */
verilog/udp_app_pkg.sv
verilog/byte_fifo.sv
verilog/udp_port_filter.sv
verilog/udp_reply_header.sv
verilog/udp_loopback_core.sv
verification/udp_loopback_sva.sv
verification/tb_udp_loopback.sv

/* verification/tb_udp_loopback.sv */
module tb_udp_loopback
    import udp_app_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam ip_addr_t  LOCAL_IP    = 32'hc0a8010a;
    localparam udp_port_t LOCAL_PORT  = 16'd5001;
    localparam int        RX_FRAMES   = 16;
    localparam int        TX_FRAMES   = 5;
    localparam int        MAX_LEN     = 24;
    localparam int        STALL_LEN   = 2 ** FIFO_ADDR_WIDTH + 8;
    localparam int        TOTAL_BEATS = (RX_FRAMES + TX_FRAMES + 2) * MAX_LEN + STALL_LEN;
    localparam int        CYCLE_LIMIT = 4 * TOTAL_BEATS + 2000;

    logic        clk, rst;
    ip_addr_t    local_ip;
    udp_port_t   local_port;
    byte_t       led;
    udp_rx_hdr_t rx_hdr;
    logic        rx_hdr_valid, rx_hdr_ready;
    axis_beat_t  rx_payload;
    logic        rx_payload_valid, rx_payload_ready;
    axis_beat_t  rec;
    logic        rec_valid, rec_ready;
    axis_beat_t  send;
    logic        send_valid, send_ready;
    udp_len_t    send_length;
    logic        send_req_valid, send_req_ready;
    udp_tx_hdr_t tx_hdr;
    logic        tx_hdr_valid, tx_hdr_ready;
    axis_beat_t  tx_payload;
    logic        tx_payload_valid, tx_payload_ready;

    // Reference model
    axis_beat_t  rx_exp[$];
    axis_beat_t  tx_exp[$];
    udp_tx_hdr_t hdr_exp[$];
    axis_beat_t  tx_beat_exp;
    ip_addr_t    exp_remote_ip;
    udp_port_t   exp_remote_port;
    byte_t       exp_led;
    logic        led_check, tx_first, hold_rec, saw_stall;

    string       cur_test;
    int          errors, checks, tests, err_start, chk_start, cycles;
    int unsigned lcg_state = 53;

    udp_loopback_core UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 1103515245 + 12345;
        return lcg_state >> 16;
    endfunction

    function automatic int rand_len();
        return int'(next_rand() % MAX_LEN) + 1;
    endfunction

    task automatic check_eq(input string what, input logic [127:0] exp, input logic [127:0] act);
        checks++;
        assert (act === exp) else begin
            $display("error %s %s: expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
        end
    endtask

    // Plays the UDP stack delivering one parsed frame
    task automatic offer_rx_frame(input bit match, input int len);
        udp_rx_hdr_t hdr;
        axis_beat_t  beat;
        hdr.src_ip   = {16'(next_rand()), 16'(next_rand())};
        hdr.src_port = 16'(next_rand());
        hdr.dst_port = match ? LOCAL_PORT : LOCAL_PORT ^ (16'(next_rand()) | 16'h1);
        hdr.length   = 16'(len + 8);
        rx_hdr       = hdr;
        rx_hdr_valid = 1'b1;
        do @(posedge clk); while (!rx_hdr_ready);
        if (match) begin
            exp_remote_ip   = hdr.src_ip;
            exp_remote_port = hdr.src_port;
        end
        #1;
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            beat.data        = 8'(next_rand());
            beat.last        = (i == len - 1);
            beat.user        = (next_rand() % 2 != 0);
            rx_payload       = beat;
            rx_payload_valid = 1'b1;
            do @(posedge clk); while (!rx_payload_ready);
            if (match) rx_exp.push_back(beat);
            #1;
        end
        rx_payload_valid = 1'b0;
    endtask

    // Plays the user: send request first, then the payload
    task automatic push_tx_frame(input int len);
        axis_beat_t beat;
        send_length    = 16'(len + 8);
        send_req_valid = 1'b1;
        do @(posedge clk); while (!send_req_ready);
        hdr_exp.push_back(udp_tx_hdr_t'{src_ip: LOCAL_IP, dst_ip: exp_remote_ip,
            src_port: LOCAL_PORT, dst_port: exp_remote_port, length: 16'(len + 8), ttl: 8'd64});
        #1;
        send_req_valid = 1'b0;
        for (int i = 0; i < len; i++) begin
            beat.data  = 8'(next_rand());
            beat.last  = (i == len - 1);
            beat.user  = (next_rand() % 2 != 0);
            send       = beat;
            send_valid = 1'b1;
            do @(posedge clk); while (!send_ready);
            tx_exp.push_back(beat);
            #1;
        end
        send_valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test  = name;
        err_start = errors;
        chk_start = checks;
    endtask

    task automatic end_test();
        while (rx_exp.size() != 0 || tx_exp.size() != 0 || hdr_exp.size() != 0 || led_check)
            @(posedge clk);
        #1;
        tests++;
        $display("test %s: %0d checks, %0d errors", cur_test, checks - chk_start,
                 errors - err_start);
    endtask

    // Random stall patterns from the user and the stack
    initial begin
        forever begin
            @(posedge clk);
            #1;
            rec_ready        = !hold_rec && (next_rand() % 4 != 0);
            tx_payload_ready = (next_rand() % 4 != 0);
            tx_hdr_ready     = (next_rand() % 2 != 0);
        end
    end

    always @(posedge clk) begin
        if (!rst && rec_valid && rec_ready) begin
            checks++;
            assert (rx_exp.size() != 0) else begin
                $display("%s: a beat came out on rec that no matching frame sent", cur_test);
                errors++;
            end
            if (rx_exp.size() != 0) check_eq("rec beat", 128'(rx_exp.pop_front()), 128'(rec));
        end
        if (hold_rec && rx_payload_valid && !rx_payload_ready) saw_stall = 1'b1;
    end

    always @(posedge clk) begin
        // LED was loaded on the previous edge
        if (led_check) begin
            check_eq("led", 128'(exp_led), 128'(led));
            led_check = 1'b0;
        end
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            checks++;
            assert (hdr_exp.size() != 0) else begin
                $display("%s: a header went out on tx_hdr without a send request", cur_test);
                errors++;
            end
            if (hdr_exp.size() != 0)
                check_eq("tx_hdr", 128'(hdr_exp.pop_front()), 128'(tx_hdr));
        end
        if (!rst && tx_payload_valid && tx_payload_ready) begin
            checks++;
            assert (tx_exp.size() != 0) else begin
                $display("%s: a beat came out on tx_payload that the user never sent",
                         cur_test);
                errors++;
            end
            if (tx_exp.size() != 0) begin
                tx_beat_exp = tx_exp.pop_front();
                check_eq("tx_payload beat", 128'(tx_beat_exp), 128'(tx_payload));
                if (tx_first) begin
                    exp_led   = tx_beat_exp.data;
                    led_check = 1'b1;
                end
                tx_first = tx_beat_exp.last;
            end
        end
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycles);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        local_ip = LOCAL_IP;
        local_port = LOCAL_PORT;
        rx_hdr = '0;
        rx_hdr_valid = 1'b0;
        rx_payload = '0;
        rx_payload_valid = 1'b0;
        rec_ready = 1'b0;
        send = '0;
        send_valid = 1'b0;
        send_length = '0;
        send_req_valid = 1'b0;
        tx_hdr_ready = 1'b0;
        tx_payload_ready = 1'b0;
        {hold_rec, saw_stall, led_check, tx_first} = 4'b0001;
        {errors, checks, tests} = '0;
        exp_remote_ip   = 32'hc0a80164;
        exp_remote_port = 16'd60000;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("reset");
        check_eq("handshake outputs", 128'(6'b100010), 128'({rx_hdr_ready, rx_payload_ready,
                 rec_valid, tx_hdr_valid, send_ready, tx_payload_valid}));
        check_eq("led", 128'(8'h00), 128'(led));
        end_test();

        start_test("tx_default");
        push_tx_frame(rand_len());
        end_test();

        // Last frame always matches so the reply test sees a new remote end
        start_test("rx_random");
        for (int i = 0; i < RX_FRAMES; i++)
            offer_rx_frame(i == RX_FRAMES - 1 || next_rand() % 2 == 0, rand_len());
        end_test();

        start_test("tx_reply");
        push_tx_frame(rand_len());
        end_test();

        start_test("rx_stall");
        hold_rec  = 1'b1;
        saw_stall = 1'b0;
        fork
            offer_rx_frame(1'b1, STALL_LEN);
            begin
                repeat (2 * STALL_LEN) @(posedge clk);
                checks++;
                assert (saw_stall) else begin
                    $display("rx_stall: rx_payload_ready stayed high with the FIFO full");
                    errors++;
                end
                hold_rec = 1'b0;
            end
        join
        end_test();

        start_test("tx_random");
        for (int i = 0; i < TX_FRAMES; i++)
            push_tx_frame(rand_len());
        end_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

/* verification/udp_loopback_sva.sv */
module udp_loopback_sva
    import udp_app_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input axis_beat_t  rec,
    input logic        rec_valid,
    input logic        rec_ready,
    input udp_tx_hdr_t tx_hdr,
    input logic        tx_hdr_valid,
    input logic        tx_hdr_ready,
    input logic        rx_hdr_ready,
    input logic        rx_payload_ready
);
    timeunit 1ns;
    timeprecision 1ps;

    // A stalled beat stays put until the user takes it
    rec_hold: assert property (@(posedge clk) disable iff (rst)
        rec_valid && !rec_ready |=> rec_valid && $stable(rec))
        else $error("rec beat changed while stalled");

    tx_hdr_hold: assert property (@(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=> tx_hdr_valid && $stable(tx_hdr))
        else $error("tx_hdr changed while stalled");

    // Header and payload phases never overlap
    phase_excl: assert property (@(posedge clk) disable iff (rst)
        !(rx_hdr_ready && rx_payload_ready))
        else $error("rx_payload_ready high while waiting for a header");

endmodule

bind udp_loopback_core udp_loopback_sva handshake_checks (.*);

/* verilog/byte_fifo.sv */
module byte_fifo
    import udp_app_pkg::*;
#(
    parameter int ADDR_WIDTH = 4
) (
    input  logic       clk,
    input  logic       rst,

    input  axis_beat_t in_beat,
    input  logic       in_valid,
    output logic       in_ready,

    output axis_beat_t out_beat,
    output logic       out_valid,
    input  logic       out_ready
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    axis_beat_t mem [DEPTH];

    // Extra top bit separates full from empty
    logic [ADDR_WIDTH:0] wr_ptr;
    logic [ADDR_WIDTH:0] rd_ptr;
    logic                full;
    logic                empty;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[ADDR_WIDTH] != rd_ptr[ADDR_WIDTH]) &&
                   (wr_ptr[ADDR_WIDTH-1:0] == rd_ptr[ADDR_WIDTH-1:0]);

    assign in_ready  = !full;
    assign out_valid = !empty;
    assign out_beat  = mem[rd_ptr[ADDR_WIDTH-1:0]];

    // Storage array
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            mem[wr_ptr[ADDR_WIDTH-1:0]] <= in_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (in_valid && in_ready) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid && out_ready) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

endmodule

/* verilog/udp_app_pkg.sv */
package udp_app_pkg;

    // Field widths with a meaning of their own
    typedef logic [7:0]  byte_t;
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;
    typedef logic [15:0] udp_len_t;

    // One payload beat of a byte stream
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

    // Parsed header handed up by the UDP stack
    typedef struct packed {
        ip_addr_t  src_ip;
        udp_port_t src_port;
        udp_port_t dst_port;
        udp_len_t  length;
    } udp_rx_hdr_t;

    // Header handed down to the UDP stack for a send
    typedef struct packed {
        ip_addr_t   src_ip;
        ip_addr_t   dst_ip;
        udp_port_t  src_port;
        udp_port_t  dst_port;
        udp_len_t   length;
        logic [7:0] ttl;
    } udp_tx_hdr_t;

    typedef enum logic [1:0] {
        FILTER_IDLE,
        FILTER_PASS,
        FILTER_DROP
    } filter_state_t;

    // 16 entries per payload FIFO
    localparam int FIFO_ADDR_WIDTH = 4;

    // Remote end used until the first accepted frame
    localparam ip_addr_t  DEFAULT_REMOTE_IP   = {8'd192, 8'd168, 8'd1, 8'd100};
    localparam udp_port_t DEFAULT_REMOTE_PORT = 16'd60000;
    localparam logic [7:0] REPLY_TTL          = 8'd64;

endpackage

/* verilog/udp_loopback_core.sv */
module udp_loopback_core
    import udp_app_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    // Static configuration
    input  ip_addr_t    local_ip,
    input  udp_port_t   local_port,

    output byte_t       led,

    // Receive side from the UDP stack
    input  udp_rx_hdr_t rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,
    input  axis_beat_t  rx_payload,
    input  logic        rx_payload_valid,
    output logic        rx_payload_ready,

    // Received payload to the user
    output axis_beat_t  rec,
    output logic        rec_valid,
    input  logic        rec_ready,

    // Payload and send requests from the user
    input  axis_beat_t  send,
    input  logic        send_valid,
    output logic        send_ready,
    input  udp_len_t    send_length,
    input  logic        send_req_valid,
    output logic        send_req_ready,

    // Transmit side to the UDP stack
    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready,
    output axis_beat_t  tx_payload,
    output logic        tx_payload_valid,
    input  logic        tx_payload_ready
);

    axis_beat_t pass_beat;
    logic       pass_valid;
    logic       pass_ready;
    logic       sender_update;
    ip_addr_t   sender_ip;
    udp_port_t  sender_port;
    byte_t      led_reg;
    logic       tx_in_frame;

    udp_port_filter filter (
        .clk(clk), .rst(rst), .local_port(local_port),
        .rx_hdr(rx_hdr), .rx_hdr_valid(rx_hdr_valid), .rx_hdr_ready(rx_hdr_ready),
        .rx_payload(rx_payload), .rx_payload_valid(rx_payload_valid),
        .rx_payload_ready(rx_payload_ready),
        .pass_beat(pass_beat), .pass_valid(pass_valid), .pass_ready(pass_ready),
        .sender_update(sender_update), .sender_ip(sender_ip), .sender_port(sender_port)
    );

    byte_fifo #(.ADDR_WIDTH(FIFO_ADDR_WIDTH)) rx_fifo (
        .clk(clk), .rst(rst),
        .in_beat(pass_beat), .in_valid(pass_valid), .in_ready(pass_ready),
        .out_beat(rec), .out_valid(rec_valid), .out_ready(rec_ready)
    );

    byte_fifo #(.ADDR_WIDTH(FIFO_ADDR_WIDTH)) tx_fifo (
        .clk(clk), .rst(rst),
        .in_beat(send), .in_valid(send_valid), .in_ready(send_ready),
        .out_beat(tx_payload), .out_valid(tx_payload_valid), .out_ready(tx_payload_ready)
    );

    udp_reply_header reply (
        .clk(clk), .rst(rst), .local_ip(local_ip), .local_port(local_port),
        .sender_update(sender_update), .sender_ip(sender_ip), .sender_port(sender_port),
        .send_length(send_length), .send_req_valid(send_req_valid),
        .send_req_ready(send_req_ready),
        .tx_hdr(tx_hdr), .tx_hdr_valid(tx_hdr_valid), .tx_hdr_ready(tx_hdr_ready)
    );

    // First byte of each outgoing frame goes to the LEDs
    always_ff @(posedge clk) begin
        if (rst) begin
            led_reg     <= '0;
            tx_in_frame <= 1'b0;
        end else if (tx_payload_valid && tx_payload_ready) begin
            if (!tx_in_frame) begin
                led_reg <= tx_payload.data;
            end
            tx_in_frame <= !tx_payload.last;
        end
    end

    assign led = led_reg;

endmodule

/* verilog/udp_port_filter.sv */
module udp_port_filter
    import udp_app_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  udp_port_t   local_port,

    input  udp_rx_hdr_t rx_hdr,
    input  logic        rx_hdr_valid,
    output logic        rx_hdr_ready,

    input  axis_beat_t  rx_payload,
    input  logic        rx_payload_valid,
    output logic        rx_payload_ready,

    output axis_beat_t  pass_beat,
    output logic        pass_valid,
    input  logic        pass_ready,

    output logic        sender_update,
    output ip_addr_t    sender_ip,
    output udp_port_t   sender_port
);

    filter_state_t state;
    logic          hdr_xfer;
    logic          beat_xfer;
    logic          port_match;

    assign hdr_xfer   = rx_hdr_valid && rx_hdr_ready;
    assign beat_xfer  = rx_payload_valid && rx_payload_ready;
    assign port_match = (rx_hdr.dst_port == local_port);

    // Headers only between frames
    assign rx_hdr_ready = (state == FILTER_IDLE);

    // Drop drains at full rate, pass follows the receive FIFO
    assign rx_payload_ready = (state == FILTER_DROP) ||
                              ((state == FILTER_PASS) && pass_ready);

    assign pass_beat  = rx_payload;
    assign pass_valid = (state == FILTER_PASS) && rx_payload_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FILTER_IDLE;
            sender_update <= 1'b0;
        end else begin
            sender_update <= hdr_xfer && port_match;
            case (state)
                FILTER_IDLE: begin
                    if (hdr_xfer) begin
                        state <= port_match ? FILTER_PASS : FILTER_DROP;
                    end
                end
                FILTER_PASS, FILTER_DROP: begin
                    if (beat_xfer && rx_payload.last) begin
                        state <= FILTER_IDLE;
                    end
                end
                default: state <= FILTER_IDLE;
            endcase
        end
    end

    // Sender of the frame being accepted
    always_ff @(posedge clk) begin
        if (hdr_xfer && port_match) begin
            sender_ip   <= rx_hdr.src_ip;
            sender_port <= rx_hdr.src_port;
        end
    end

endmodule

/* verilog/udp_reply_header.sv */
module udp_reply_header
    import udp_app_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  ip_addr_t    local_ip,
    input  udp_port_t   local_port,

    input  logic        sender_update,
    input  ip_addr_t    sender_ip,
    input  udp_port_t   sender_port,

    input  udp_len_t    send_length,
    input  logic        send_req_valid,
    output logic        send_req_ready,

    output udp_tx_hdr_t tx_hdr,
    output logic        tx_hdr_valid,
    input  logic        tx_hdr_ready
);

    ip_addr_t  remote_ip;
    udp_port_t remote_port;
    logic      hdr_pending;

    assign send_req_ready = !hdr_pending;
    assign tx_hdr_valid   = hdr_pending;

    // Remote end of the last accepted frame
    always_ff @(posedge clk) begin
        if (rst) begin
            remote_ip   <= DEFAULT_REMOTE_IP;
            remote_port <= DEFAULT_REMOTE_PORT;
        end else if (sender_update) begin
            remote_ip   <= sender_ip;
            remote_port <= sender_port;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_pending <= 1'b0;
        end else if (send_req_valid && send_req_ready) begin
            hdr_pending <= 1'b1;
        end else if (tx_hdr_valid && tx_hdr_ready) begin
            hdr_pending <= 1'b0;
        end
    end

    // Header stays frozen while pending
    always_ff @(posedge clk) begin
        if (send_req_valid && send_req_ready) begin
            tx_hdr <= '{src_ip: local_ip, dst_ip: remote_ip, src_port: local_port,
                        dst_port: remote_port, length: send_length, ttl: REPLY_TTL};
        end
    end

endmodule
